//--- hw/dcache_pkg.sv
`default_nettype none

package dcache_pkg;

  // word geometry
  localparam int WORD_BYTES = 4;
  // two-way set associative
  localparam int WAYS = 2;
  // banks are word interleaved on the low address bit
  localparam int BANK_BITS = 1;
  localparam int BANKS = 1 << BANK_BITS;
  // word address within a 4 KiB page
  localparam int ADDR_BITS = 10;
  // rows per bank per way
  localparam int BANK_DEPTH = 1 << (ADDR_BITS - BANK_BITS);
  // load ports issued per cycle
  localparam int RD_PORTS = 2;

  // one data word, byte addressable
  typedef logic [WORD_BYTES-1:0][7:0] word_t;

  // one enable per byte lane
  typedef logic [WORD_BYTES-1:0] byte_en_t;

  // full word address, bank bits at the bottom
  typedef logic [ADDR_BITS-1:0] word_addr_t;

  // row inside one bank
  typedef logic [ADDR_BITS-BANK_BITS-1:0] bank_addr_t;

  // bank number
  typedef logic [BANK_BITS-1:0] bank_id_t;

  // way selector
  typedef logic [$clog2(WAYS)-1:0] way_t;

  // same row from every way, way 0 in the low word
  typedef word_t [WAYS-1:0] way_data_t;

endpackage

`default_nettype wire

//--- hw/bank_port_if.sv
`timescale 1ns/1ps
`default_nettype none

interface bank_port_if;

  import dcache_pkg::*;

  // read row per bank, already steered by the arbiter
  bank_addr_t [BANKS-1:0] rd_addr;

  // write row, common to all banks
  bank_addr_t wr_addr;

  // write payload, common to all banks and ways
  word_t wr_data;

  // byte enables, only the addressed bank and way nonzero
  byte_en_t [BANKS-1:0][WAYS-1:0] wr_be;

  // both ways of each bank, one cycle after rd_addr
  way_data_t [BANKS-1:0] rd_data;

  // arbiter side
  modport arb (
    output rd_addr,
    output wr_addr,
    output wr_data,
    output wr_be
  );

  // storage side
  modport array (
    input  rd_addr,
    input  wr_addr,
    input  wr_data,
    input  wr_be,
    output rd_data
  );

endinterface

`default_nettype wire

//--- hw/byte_en_ram.sv
`timescale 1ns/1ps
`default_nettype none

module byte_en_ram #(
  parameter int DEPTH = dcache_pkg::BANK_DEPTH
) (
  input  logic                     clk,
  input  logic [$clog2(DEPTH)-1:0] wr_addr,
  input  dcache_pkg::byte_en_t     wr_be,
  input  dcache_pkg::word_t        wr_data,
  input  logic [$clog2(DEPTH)-1:0] rd_addr,
  output dcache_pkg::word_t        rd_data
);

  import dcache_pkg::*;

  // storage, contents undefined until written
  word_t mem [DEPTH];

  // byte lane writes
  always_ff @(posedge clk) begin
    for (int b = 0; b < WORD_BYTES; b++) begin
      if (wr_be[b]) begin
        mem[wr_addr][b] <= wr_data[b];
      end
    end
  end

  // registered read
  // same-row collision returns the old word
  always_ff @(posedge clk) begin
    rd_data <= mem[rd_addr];
  end

  // an X enable would corrupt a random subset of lanes
  a_be_known : assert property (
    @(posedge clk) !$isunknown(wr_be)
  ) else $error("byte_en_ram: unknown write enable");

endmodule

`default_nettype wire

//--- hw/bank_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module bank_arbiter (
  input  logic [dcache_pkg::RD_PORTS-1:0]                         rd_valid,
  input  dcache_pkg::word_addr_t [dcache_pkg::RD_PORTS-1:0]       rd_addr,
  input  dcache_pkg::byte_en_t                                    wr_be,
  input  dcache_pkg::way_t                                        wr_way,
  input  dcache_pkg::word_addr_t                                  wr_addr,
  input  dcache_pkg::word_t                                       wr_data,
  output logic                                                    conflict,
  output logic [dcache_pkg::RD_PORTS-1:0]                         grant,
  bank_port_if.arb                                                bport
);

  import dcache_pkg::*;

  // per port bank and row split
  bank_id_t   [RD_PORTS-1:0] rd_bank;
  bank_addr_t [RD_PORTS-1:0] rd_row;
  bank_id_t                  wr_bank;
  logic                      same_bank;
  logic                      same_word;

  for (genvar p = 0; p < RD_PORTS; p++) begin : g_port
    assign rd_bank[p] = rd_addr[p][BANK_BITS-1:0];
    assign rd_row[p]  = rd_addr[p][ADDR_BITS-1:BANK_BITS];
  end

  assign same_bank = (rd_bank[0] == rd_bank[1]);
  // same word is a shared row read, not a clash
  assign same_word = (rd_addr[0] == rd_addr[1]);

  // both live, one bank, two rows
  assign conflict = (&rd_valid) & same_bank & ~same_word;

  // port 0 always wins
  assign grant[0] = rd_valid[0];
  // port 1 only when it does not fight port 0
  assign grant[1] = rd_valid[1] & (~rd_valid[0] | ~same_bank | same_word);

  // write side, row and data broadcast
  assign wr_bank       = wr_addr[BANK_BITS-1:0];
  assign bport.wr_addr = wr_addr[ADDR_BITS-1:BANK_BITS];
  assign bport.wr_data = wr_data;

  for (genvar b = 0; b < BANKS; b++) begin : g_bank
    // bank goes to port 0 when it asks, else port 1 row
    assign bport.rd_addr[b] = (rd_valid[0] && rd_bank[0] == bank_id_t'(b)) ?
                              rd_row[0] : rd_row[1];
    for (genvar w = 0; w < WAYS; w++) begin : g_way
      // enables land on exactly one bank and way
      assign bport.wr_be[b][w] = (wr_bank == bank_id_t'(b) && wr_way == way_t'(w)) ?
                                 wr_be : '0;
    end
  end

  // port 1 drops out whenever conflict is raised
  always_comb begin
    a_conflict_grant : assert final (!(conflict && grant[1]))
      else $error("bank_arbiter: port 1 granted during a conflict");
  end

  // a granted port finds its own row on its bank
  for (genvar p = 0; p < RD_PORTS; p++) begin : g_steer_chk
    always_comb begin
      a_steer_row : assert final (!grant[p] || bport.rd_addr[rd_bank[p]] == rd_row[p])
        else $error("bank_arbiter: granted port %0d steered to the wrong row", p);
    end
  end

endmodule

`default_nettype wire

//--- hw/bank_array.sv
`timescale 1ns/1ps
`default_nettype none

module bank_array (
  input  logic        clk,
  bank_port_if.array  bport
);

  import dcache_pkg::*;

  // one RAM per bank per way
  for (genvar b = 0; b < BANKS; b++) begin : g_bank
    // both ways of this bank, gathered before driving the interface
    way_data_t way_rd;

    for (genvar w = 0; w < WAYS; w++) begin : g_way
      // row shared across ways, enable picks the way
      byte_en_ram #(
        .DEPTH   (BANK_DEPTH)
      ) ram_i (
        .clk     (clk),
        .wr_addr (bport.wr_addr),
        .wr_be   (bport.wr_be[b][w]),
        .wr_data (bport.wr_data),
        .rd_addr (bport.rd_addr[b]),
        .rd_data (way_rd[w])
      );
    end

    // way select happens later in the controller
    assign bport.rd_data[b] = way_rd;
  end

endmodule

`default_nettype wire

//--- hw/read_forward_stage.sv
`timescale 1ns/1ps
`default_nettype none

module read_forward_stage (
  input  logic                                              clk,
  input  logic                                              arst_n,
  input  logic [dcache_pkg::RD_PORTS-1:0]                   grant,
  input  dcache_pkg::word_addr_t [dcache_pkg::RD_PORTS-1:0] rd_addr,
  input  dcache_pkg::byte_en_t                              wr_be,
  input  dcache_pkg::way_t                                  wr_way,
  input  dcache_pkg::word_addr_t                            wr_addr,
  input  dcache_pkg::word_t                                 wr_data,
  input  dcache_pkg::way_data_t [dcache_pkg::BANKS-1:0]     bank_rd_data,
  output dcache_pkg::way_data_t [dcache_pkg::RD_PORTS-1:0]  rd_data,
  output logic [dcache_pkg::RD_PORTS-1:0]                   rd_resp_valid
);

  import dcache_pkg::*;

  // read side, one cycle behind the request
  word_addr_t [RD_PORTS-1:0] rd_addr_q;
  logic       [RD_PORTS-1:0] grant_q;

  // write from the request cycle
  // already in flight to the RAM, too late for that read
  byte_en_t   wr_be_q;
  way_t       wr_way_q;
  word_addr_t wr_addr_q;
  word_t      wr_data_q;

  // bank pick plus both forward overlays
  way_data_t [RD_PORTS-1:0] merged;
  bank_id_t  [RD_PORTS-1:0] bank_q;

  // control, cleared on reset
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      grant_q       <= '0;
      wr_be_q       <= '0;
      rd_resp_valid <= '0;
    end else begin
      grant_q       <= grant;
      wr_be_q       <= wr_be;
      // response valid two cycles after grant
      rd_resp_valid <= grant_q;
    end
  end

  // payload, no reset
  always_ff @(posedge clk) begin
    rd_addr_q <= rd_addr;
    wr_way_q  <= wr_way;
    wr_addr_q <= wr_addr;
    wr_data_q <= wr_data;
  end

  for (genvar p = 0; p < RD_PORTS; p++) begin : g_port
    assign bank_q[p] = rd_addr_q[p][BANK_BITS-1:0];
  end

  // older write first, then the current one
  // so the later write wins on a shared byte
  always_comb begin
    for (int p = 0; p < RD_PORTS; p++) begin
      merged[p] = bank_rd_data[bank_q[p]];
      for (int b = 0; b < WORD_BYTES; b++) begin
        if (wr_be_q[b] && wr_addr_q == rd_addr_q[p]) begin
          merged[p][wr_way_q][b] = wr_data_q[b];
        end
        if (wr_be[b] && wr_addr == rd_addr_q[p]) begin
          merged[p][wr_way][b] = wr_data[b];
        end
      end
    end
  end

  // response register
  always_ff @(posedge clk) begin
    rd_data <= merged;
  end

  // forwarded way must name a real RAM
  a_way_range : assert property (
    @(posedge clk) disable iff (!arst_n)
    (|wr_be_q) |-> (!$isunknown(wr_way_q) && int'(wr_way_q) < WAYS)
  ) else $error("read_forward_stage: registered write way unknown or out of range");

endmodule

`default_nettype wire

//--- hw/dcache_datapath.sv
`timescale 1ns/1ps
`default_nettype none

module dcache_datapath (
  input  logic                                              clk,
  input  logic                                              arst_n,
  input  logic [dcache_pkg::RD_PORTS-1:0]                   rd_valid,
  input  dcache_pkg::word_addr_t [dcache_pkg::RD_PORTS-1:0] rd_addr,
  input  dcache_pkg::byte_en_t                              wr_be,
  input  dcache_pkg::way_t                                  wr_way,
  input  dcache_pkg::word_addr_t                            wr_addr,
  input  dcache_pkg::word_t                                 wr_data,
  output logic                                              conflict,
  output dcache_pkg::way_data_t [dcache_pkg::RD_PORTS-1:0]  rd_data,
  output logic [dcache_pkg::RD_PORTS-1:0]                   rd_resp_valid
);

  import dcache_pkg::*;

  // ports that actually got a bank this cycle
  logic [RD_PORTS-1:0] grant;

  // steered addresses and enables into the banks
  bank_port_if bport_i ();

  // bank decode, conflict, steering
  bank_arbiter arbiter_i (
    .rd_valid (rd_valid),
    .rd_addr  (rd_addr),
    .wr_be    (wr_be),
    .wr_way   (wr_way),
    .wr_addr  (wr_addr),
    .wr_data  (wr_data),
    .conflict (conflict),
    .grant    (grant),
    .bport    (bport_i)
  );

  // data RAMs, one cycle read
  bank_array array_i (
    .clk   (clk),
    .bport (bport_i)
  );

  // bank select, forwarding
  // response out at t+2
  read_forward_stage forward_i (
    .clk           (clk),
    .arst_n        (arst_n),
    .grant         (grant),
    .rd_addr       (rd_addr),
    .wr_be         (wr_be),
    .wr_way        (wr_way),
    .wr_addr       (wr_addr),
    .wr_data       (wr_data),
    .bank_rd_data  (bport_i.rd_data),
    .rd_data       (rd_data),
    .rd_resp_valid (rd_resp_valid)
  );

endmodule

`default_nettype wire

//--- sim/tb_dcache_datapath.sv
`timescale 1ns/1ps
`default_nettype none

module tb_dcache_datapath;

  import dcache_pkg::*;

  localparam int MAX_STEPS     = 256;
  localparam int RAND_STEPS    = 64;
  localparam int DRAIN_TIMEOUT = 16;

  logic                      clk;
  logic                      arst_n;
  logic       [RD_PORTS-1:0] rd_valid;
  word_addr_t [RD_PORTS-1:0] rd_addr;
  byte_en_t                  wr_be;
  way_t                      wr_way;
  word_addr_t                wr_addr;
  word_t                     wr_data;
  logic                      conflict;
  way_data_t  [RD_PORTS-1:0] rd_data;
  logic       [RD_PORTS-1:0] rd_resp_valid;

  // stimulus table, one entry per cycle, expected conflict in the last column
  string      t_name [$];
  logic [1:0] t_rv   [$];
  word_addr_t t_a0   [$];
  word_addr_t t_a1   [$];
  byte_en_t   t_be   [$];
  way_t       t_way  [$];
  word_addr_t t_wa   [$];
  word_t      t_wd   [$];
  logic       t_conf [$];

  // expected response per table entry
  way_data_t           exp_data  [MAX_STEPS][RD_PORTS];
  logic [RD_PORTS-1:0] exp_valid [MAX_STEPS];

  // reference model, bytes of both ways
  logic [7:0] model_mem [WAYS][1<<ADDR_BITS][WORD_BYTES];

  int          errors;
  int          checks;
  logic [31:0] rng;
  int          n_steps;

  dcache_datapath dut_i (
    .clk           (clk),
    .arst_n        (arst_n),
    .rd_valid      (rd_valid),
    .rd_addr       (rd_addr),
    .wr_be         (wr_be),
    .wr_way        (wr_way),
    .wr_addr       (wr_addr),
    .wr_data       (wr_data),
    .conflict      (conflict),
    .rd_data       (rd_data),
    .rd_resp_valid (rd_resp_valid)
  );

  // 100 ns clock
  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x ^= x << 13;
    x ^= x >> 17;
    x ^= x << 5;
    return x;
  endfunction

  // both live, one bank, two different words
  function automatic logic expect_conflict(input logic [1:0] rv, input word_addr_t a0,
                                           input word_addr_t a1);
    return rv[0] && rv[1] && (a0[BANK_BITS-1:0] == a1[BANK_BITS-1:0]) && (a0 != a1);
  endfunction

  // init pattern, every address bit and the way show up
  function automatic word_t fill_word(input int a, input int w);
    return {4'(w) + 4'ha, 2'b00, 10'(a), 16'(a * 16'h9e37)};
  endfunction

  task automatic add_step(input string name, input logic [1:0] rv, input word_addr_t a0,
                          input word_addr_t a1, input byte_en_t be, input way_t way,
                          input word_addr_t wa, input word_t wd, input logic conf);
    t_name.push_back(name);
    t_rv.push_back(rv);
    t_a0.push_back(a0);
    t_a1.push_back(a1);
    t_be.push_back(be);
    t_way.push_back(way);
    t_wa.push_back(wa);
    t_wd.push_back(wd);
    t_conf.push_back(conf);
  endtask

  task automatic read_step(input string name, input logic [1:0] rv, input word_addr_t a0,
                           input word_addr_t a1, input logic conf);
    add_step(name, rv, a0, a1, '0, '0, '0, '0, conf);
  endtask

  task automatic write_step(input string name, input byte_en_t be, input way_t way,
                            input word_addr_t wa, input word_t wd);
    add_step(name, 2'b00, '0, '0, be, way, wa, wd, 1'b0);
  endtask

  task automatic build_directed();
    // full words into 0x010..0x017, both ways
    for (int a = 16; a < 24; a++) begin
      for (int w = 0; w < WAYS; w++) begin
        write_step("init", 4'hf, way_t'(w), word_addr_t'(a), fill_word(a, w));
      end
    end
    // different banks, plain RAM path
    read_step("two_banks", 2'b11, 10'h010, 10'h011, 1'b0);
    read_step("two_banks", 2'b11, 10'h017, 10'h012, 1'b0);
    // byte merge, one way only
    write_step("partial", 4'b0101, 1'b1, 10'h014, 32'hdead_beef);
    write_step("partial", 4'b1000, 1'b0, 10'h015, 32'h7700_0000);
    read_step("idle", 2'b00, 10'h000, 10'h000, 1'b0);
    read_step("partial", 2'b11, 10'h014, 10'h015, 1'b0);
    // same bank, different words
    read_step("conflict", 2'b11, 10'h010, 10'h012, 1'b1);
    // same word shares the row
    read_step("same_word", 2'b11, 10'h013, 10'h013, 1'b0);
    read_step("port1_only", 2'b10, 10'h016, 10'h014, 1'b0);
    read_step("port0_only", 2'b01, 10'h016, 10'h014, 1'b0);
    // write in the read cycle
    add_step("fwd_t", 2'b11, 10'h016, 10'h017, 4'hf, 1'b0, 10'h016, 32'h1234_5678, 1'b0);
    // write one cycle after the read
    read_step("fwd_t1", 2'b01, 10'h017, 10'h000, 1'b0);
    write_step("fwd_t1", 4'b0011, 1'b1, 10'h017, 32'hcafe_f00d);
    // both cycles, byte 1 from the later one
    add_step("fwd_both", 2'b10, 10'h000, 10'h012, 4'b0011, 1'b1, 10'h012, 32'h0000_aabb, 1'b0);
    write_step("fwd_both", 4'b0110, 1'b1, 10'h012, 32'h00cc_dd00);
  endtask

  // random traffic over the initialized words
  task automatic build_random();
    logic [1:0] rv;
    word_addr_t a0;
    word_addr_t a1;
    word_addr_t wa;
    for (int i = 0; i < RAND_STEPS; i++) begin
      rng = xorshift32(rng);
      rv  = rng[1:0];
      a0  = 10'h010 + word_addr_t'(rng[4:2]);
      a1  = 10'h010 + word_addr_t'(rng[7:5]);
      wa  = 10'h010 + word_addr_t'(rng[15:13]);
      add_step("random", rv, a0, a1, rng[11:8], way_t'(rng[12]), wa,
               xorshift32(rng), expect_conflict(rv, a0, a1));
      rng = xorshift32(rng);
    end
  endtask

  task automatic model_write(input int idx);
    for (int b = 0; b < WORD_BYTES; b++) begin
      if (t_be[idx][b]) begin
        model_mem[t_way[idx]][t_wa[idx]][b] = t_wd[idx][b];
      end
    end
  endtask

  function automatic way_data_t model_word(input word_addr_t a);
    way_data_t r;
    for (int w = 0; w < WAYS; w++) begin
      for (int b = 0; b < WORD_BYTES; b++) begin
        r[w][b] = model_mem[w][a][b];
      end
    end
    return r;
  endfunction

  // model now holds every write up to t+1
  task automatic record_expect(input int idx);
    exp_valid[idx]   = {t_rv[idx][1] & ~t_conf[idx], t_rv[idx][0]};
    exp_data[idx][0] = model_word(t_a0[idx]);
    exp_data[idx][1] = model_word(t_a1[idx]);
  endtask

  task automatic drive_step(input int idx);
    rd_valid   = t_rv[idx];
    rd_addr[0] = t_a0[idx];
    rd_addr[1] = t_a1[idx];
    wr_be      = t_be[idx];
    wr_way     = t_way[idx];
    wr_addr    = t_wa[idx];
    wr_data    = t_wd[idx];
  endtask

  task automatic drive_idle();
    rd_valid = '0;
    rd_addr  = '0;
    wr_be    = '0;
    wr_way   = '0;
    wr_addr  = '0;
    wr_data  = '0;
  endtask

  task automatic check_conflict(input int idx);
    checks++;
    assert (conflict === t_conf[idx]) else begin
      errors++;
      $display("ERROR %s step %0d conflict: expected %b actual %b",
               t_name[idx], idx, t_conf[idx], conflict);
    end
  endtask

  task automatic check_response(input int idx);
    for (int p = 0; p < RD_PORTS; p++) begin
      checks++;
      assert (rd_resp_valid[p] === exp_valid[idx][p]) else begin
        errors++;
        $display("ERROR %s step %0d port %0d rd_resp_valid: expected %b actual %b",
                 t_name[idx], idx, p, exp_valid[idx][p], rd_resp_valid[p]);
      end
      if (exp_valid[idx][p]) begin
        checks++;
        assert (rd_data[p] === exp_data[idx][p]) else begin
          errors++;
          $display("ERROR %s step %0d port %0d rd_data: expected %h actual %h",
                   t_name[idx], idx, p, exp_data[idx][p], rd_data[p]);
        end
      end
    end
  endtask

  // pipeline must empty once inputs go idle
  task automatic wait_resp_idle();
    int cnt;
    cnt = 0;
    while (rd_resp_valid !== '0 && cnt < DRAIN_TIMEOUT) begin
      @(posedge clk);
      #5;
      cnt++;
    end
    if (rd_resp_valid !== '0) begin
      errors++;
      $display("timeout: read responses still valid after %0d idle cycles", DRAIN_TIMEOUT);
    end
  endtask

  initial begin
    errors  = 0;
    checks  = 0;
    rng     = 32'hc340_e330;
    arst_n  = 1'b0;
    drive_idle();
    build_directed();
    build_random();
    n_steps = t_name.size();
    repeat (5) @(posedge clk);
    #5;
    checks++;
    assert (rd_resp_valid === '0) else begin
      errors++;
      $display("ERROR reset rd_resp_valid: expected %b actual %b",
               {RD_PORTS{1'b0}}, rd_resp_valid);
    end
    arst_n = 1'b1;
    // responses for step c-2 are checked before step c is driven
    for (int c = 0; c < n_steps + 2; c++) begin
      @(posedge clk);
      #5;
      if (c >= 2) begin
        check_response(c - 2);
      end else begin
        checks++;
        assert (rd_resp_valid === '0) else begin
          errors++;
          $display("ERROR post_reset step %0d rd_resp_valid: expected %b actual %b",
                   c, {RD_PORTS{1'b0}}, rd_resp_valid);
        end
      end
      if (c < n_steps) begin
        drive_step(c);
        model_write(c);
      end else begin
        drive_idle();
      end
      if (c >= 1 && c - 1 < n_steps) begin
        record_expect(c - 1);
      end
      // conflict is combinational, sample it mid cycle
      if (c < n_steps) begin
        #10;
        check_conflict(c);
      end
    end
    wait_resp_idle();
    $display("checks=%0d errors=%0d", checks, errors);
    if (errors == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- dcache_datapath.f
hw/dcache_pkg.sv
hw/bank_port_if.sv
hw/byte_en_ram.sv
hw/bank_arbiter.sv
hw/bank_array.sv
hw/read_forward_stage.sv
hw/dcache_datapath.sv
sim/tb_dcache_datapath.sv

//--- run_sim.sh
#!/bin/sh
# build and run the dcache data path testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing --assert -Wno-fatal \
  -f dcache_datapath.f \
  --top-module tb_dcache_datapath \
  -Mdir "$OBJ" -o tb_sim
if [ $? -ne 0 ]; then
  echo "verilator compile failed"
  exit 1
fi

"./$OBJ/tb_sim" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "SOME TESTS FAILED" "$LOG"; then
  echo "simulation reported failures"
  exit 1
fi

echo "simulation passed"
exit 0
